/* src/ext_dev_defines.svh */
/* Shared constants for the external device harness.
   Register offsets are full 32-bit addresses as seen on the register bus. */
`ifndef EXT_DEV_DEFINES_SVH
`define EXT_DEV_DEFINES_SVH

// Slow memory geometry
`define EXT_MEM_WORDS 128
`define EXT_DATA_W 32

// Worst-case grant delay of the slow memory, in cycles
`define EXT_MAX_GNT_DLY 3

// Memory-copy peripheral register map
`define MC_REG_SRC 32'h0
`define MC_REG_DST 32'h4
// Writing SIZE with a nonzero word count starts a copy
`define MC_REG_SIZE 32'h8
// Read only, bit 0 is busy
`define MC_REG_STATUS 32'hC

`endif

/* src/ext_dev_pkg.sv */
/* Types shared by the external device blocks.
   Widths follow the macros in ext_dev_defines.svh. */
`include "ext_dev_defines.svh"

package ext_dev_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [`EXT_DATA_W-1:0] data_t;
  typedef logic [`EXT_DATA_W/8-1:0] strb_t;
  typedef logic [$clog2(`EXT_MEM_WORDS)-1:0] word_idx_t;

  // OBI request, held by the master until gnt
  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

  // Register bus, no wait states
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT,
    DONE
  } mc_state_e;

endpackage

/* src/slow_memory.sv */
/* Word-addressed OBI slave, one outstanding request at a time.
   Grant comes 0 to EXT_MAX_GNT_DLY cycles after req, rvalid one cycle after grant.
   Only address bits 8:2 are decoded, so the memory aliases every 512 bytes. */
`timescale 1ns/1ps
`include "ext_dev_defines.svh"

module slow_memory (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  ext_dev_pkg::obi_req_t  req_i,
  output ext_dev_pkg::obi_resp_t resp_o
);

  localparam int DLY_W = $clog2(`EXT_MAX_GNT_DLY + 1);

  ext_dev_pkg::data_t     mem [`EXT_MEM_WORDS];
  ext_dev_pkg::word_idx_t word_idx;
  ext_dev_pkg::data_t     rdata_q;
  logic                   rvalid_q;

  logic [7:0]       lfsr_q;
  logic [DLY_W-1:0] dly_new;
  logic [DLY_W-1:0] dly_cnt_q;
  logic             dly_active_q;
  logic             gnt;

  assign word_idx = req_i.addr[8:2];

  // Delay drawn for a request seen for the first time
  assign dly_new = DLY_W'(lfsr_q % (`EXT_MAX_GNT_DLY + 1));

  assign gnt = req_i.req &&
               ((!dly_active_q && dly_new == '0) || (dly_active_q && dly_cnt_q == '0));

  // Free-running LFSR, x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 8'hA5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // Grant delay counter
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dly_active_q <= 1'b0;
      dly_cnt_q    <= '0;
    end else if (gnt) begin
      dly_active_q <= 1'b0;
    end else if (req_i.req && !dly_active_q) begin
      dly_active_q <= 1'b1;
      dly_cnt_q    <= dly_new - DLY_W'(1);
    end else if (dly_active_q) begin
      dly_cnt_q <= dly_cnt_q - DLY_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  // Storage and read data, sampled at the grant
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (req_i.we) begin
        for (int b = 0; b < `EXT_DATA_W / 8; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end
      rdata_q <= mem[word_idx];
    end
  end

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

/* src/obi_arbiter.sv */
/* Two-master OBI arbiter with alternating priority and no added latency.
   Assumes the slave keeps at most one transaction outstanding. */
`timescale 1ns/1ps

module obi_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ext_dev_pkg::obi_req_t  m0_req_i,
  output ext_dev_pkg::obi_resp_t m0_resp_o,
  input  ext_dev_pkg::obi_req_t  m1_req_i,
  output ext_dev_pkg::obi_resp_t m1_resp_o,
  output ext_dev_pkg::obi_req_t  s_req_o,
  input  ext_dev_pkg::obi_resp_t s_resp_i
);

  logic sel;
  logic allow;
  logic last_q;
  logic hold_q;
  logic hold_sel_q;
  logic rsp_busy_q;
  logic rsp_owner_q;

  // A request stays with its master until granted, so the slave sees stable fields
  always_comb begin
    if (hold_q) begin
      sel = hold_sel_q;
    end else if (m0_req_i.req && m1_req_i.req) begin
      sel = ~last_q;
    end else begin
      sel = m1_req_i.req;
    end
  end

  // The next grant may land in the cycle of the pending rvalid
  assign allow = !rsp_busy_q || s_resp_i.rvalid;

  always_comb begin
    s_req_o     = sel ? m1_req_i : m0_req_i;
    s_req_o.req = (sel ? m1_req_i.req : m0_req_i.req) && allow;
  end

  assign m0_resp_o.gnt    = s_resp_i.gnt && allow && !sel;
  assign m1_resp_o.gnt    = s_resp_i.gnt && allow && sel;
  assign m0_resp_o.rvalid = s_resp_i.rvalid && rsp_busy_q && !rsp_owner_q;
  assign m1_resp_o.rvalid = s_resp_i.rvalid && rsp_busy_q && rsp_owner_q;
  assign m0_resp_o.rdata  = s_resp_i.rdata;
  assign m1_resp_o.rdata  = s_resp_i.rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q      <= 1'b1;
      hold_q      <= 1'b0;
      hold_sel_q  <= 1'b0;
      rsp_busy_q  <= 1'b0;
      rsp_owner_q <= 1'b0;
    end else begin
      if (s_req_o.req && s_resp_i.gnt) begin
        // Ownership taken at grant, kept until its rvalid
        hold_q      <= 1'b0;
        last_q      <= sel;
        rsp_busy_q  <= 1'b1;
        rsp_owner_q <= sel;
      end else begin
        if (s_req_o.req) begin
          hold_q     <= 1'b1;
          hold_sel_q <= sel;
        end
        if (s_resp_i.rvalid) begin
          rsp_busy_q <= 1'b0;
        end
      end
    end
  end

endmodule

/* src/memcopy_periph.sv */
/* Register-programmed word copy engine with an OBI master port.
   One transaction in flight; addresses should be word aligned.
   SIZE writes while busy are dropped; intr_o pulses one cycle per copy. */
`timescale 1ns/1ps
`include "ext_dev_defines.svh"

module memcopy_periph (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ext_dev_pkg::reg_req_t  reg_req_i,
  output ext_dev_pkg::reg_rsp_t  reg_rsp_o,
  output ext_dev_pkg::obi_req_t  master_req_o,
  input  ext_dev_pkg::obi_resp_t master_resp_i,
  output logic                   intr_o
);

  ext_dev_pkg::mc_state_e state_q;
  ext_dev_pkg::mc_state_e state_d;

  ext_dev_pkg::addr_t src_q;
  ext_dev_pkg::addr_t dst_q;
  ext_dev_pkg::data_t size_q;
  ext_dev_pkg::data_t size_wr_val;
  ext_dev_pkg::data_t remain_q;

  // Working copies so SRC and DST read back as programmed
  ext_dev_pkg::addr_t rd_addr_q;
  ext_dev_pkg::addr_t wr_addr_q;
  ext_dev_pkg::data_t buf_q;

  logic busy;
  logic mapped;
  logic wr_src;
  logic wr_dst;
  logic wr_size;
  logic start;

  function automatic ext_dev_pkg::data_t merge_bytes(input ext_dev_pkg::data_t old_val,
                                                     input ext_dev_pkg::data_t new_val,
                                                     input ext_dev_pkg::strb_t strb);
    ext_dev_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < `EXT_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign busy = (state_q != ext_dev_pkg::IDLE);

  // Register decode
  assign mapped = (reg_req_i.addr == `MC_REG_SRC)  || (reg_req_i.addr == `MC_REG_DST) ||
                  (reg_req_i.addr == `MC_REG_SIZE) || (reg_req_i.addr == `MC_REG_STATUS);

  assign wr_src  = reg_req_i.valid && reg_req_i.write && (reg_req_i.addr == `MC_REG_SRC);
  assign wr_dst  = reg_req_i.valid && reg_req_i.write && (reg_req_i.addr == `MC_REG_DST);
  assign wr_size = reg_req_i.valid && reg_req_i.write && (reg_req_i.addr == `MC_REG_SIZE)
                   && !busy;

  assign size_wr_val = merge_bytes(size_q, reg_req_i.wdata, reg_req_i.wstrb);
  assign start       = wr_size && (size_wr_val != '0);

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = reg_req_i.valid && !mapped;

  always_comb begin
    case (reg_req_i.addr)
      `MC_REG_SRC:    reg_rsp_o.rdata = src_q;
      `MC_REG_DST:    reg_rsp_o.rdata = dst_q;
      `MC_REG_SIZE:   reg_rsp_o.rdata = size_q;
      `MC_REG_STATUS: reg_rsp_o.rdata = {{(`EXT_DATA_W - 1){1'b0}}, busy};
      default:        reg_rsp_o.rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      size_q <= '0;
    end else begin
      if (wr_src) begin
        src_q <= merge_bytes(src_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr_dst) begin
        dst_q <= merge_bytes(dst_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr_size) begin
        size_q <= size_wr_val;
      end
    end
  end

  // Copy FSM, one read then one write per word
  always_comb begin
    state_d = state_q;
    case (state_q)
      ext_dev_pkg::IDLE:    if (start) state_d = ext_dev_pkg::RD_REQ;
      ext_dev_pkg::RD_REQ:  if (master_resp_i.gnt) state_d = ext_dev_pkg::RD_WAIT;
      ext_dev_pkg::RD_WAIT: if (master_resp_i.rvalid) state_d = ext_dev_pkg::WR_REQ;
      ext_dev_pkg::WR_REQ:  if (master_resp_i.gnt) state_d = ext_dev_pkg::WR_WAIT;
      ext_dev_pkg::WR_WAIT: begin
        if (master_resp_i.rvalid) begin
          state_d = (remain_q == ext_dev_pkg::data_t'(1)) ? ext_dev_pkg::DONE
                                                          : ext_dev_pkg::RD_REQ;
        end
      end
      default:              state_d = ext_dev_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ext_dev_pkg::IDLE;
      remain_q <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        remain_q <= size_wr_val;
      end else if (state_q == ext_dev_pkg::WR_WAIT && master_resp_i.rvalid) begin
        remain_q <= remain_q - ext_dev_pkg::data_t'(1);
      end
    end
  end

  // Addresses and the word buffer
  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_addr_q <= src_q;
      wr_addr_q <= dst_q;
    end else if (state_q == ext_dev_pkg::WR_WAIT && master_resp_i.rvalid) begin
      rd_addr_q <= rd_addr_q + 32'd4;
      wr_addr_q <= wr_addr_q + 32'd4;
    end
    if (state_q == ext_dev_pkg::RD_WAIT && master_resp_i.rvalid) begin
      buf_q <= master_resp_i.rdata;
    end
  end

  always_comb begin
    master_req_o       = '0;
    master_req_o.be    = '1;
    master_req_o.addr  = rd_addr_q;
    master_req_o.wdata = buf_q;
    if (state_q == ext_dev_pkg::RD_REQ) begin
      master_req_o.req = 1'b1;
    end else if (state_q == ext_dev_pkg::WR_REQ) begin
      master_req_o.req  = 1'b1;
      master_req_o.we   = 1'b1;
      master_req_o.addr = wr_addr_q;
    end
  end

  // Cycle after the last write's rvalid
  assign intr_o = (state_q == ext_dev_pkg::DONE);

endmodule

/* src/ext_dev_top.sv */
/* External device side of the test harness.
   Host OBI traffic takes arbiter port 0, the copy engine port 1. */
`timescale 1ns/1ps

module ext_dev_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ext_dev_pkg::reg_req_t  reg_req_i,
  output ext_dev_pkg::reg_rsp_t  reg_rsp_o,
  input  ext_dev_pkg::obi_req_t  host_req_i,
  output ext_dev_pkg::obi_resp_t host_resp_o,
  output logic                   memcopy_intr_o
);

  ext_dev_pkg::obi_req_t  mc_req;
  ext_dev_pkg::obi_resp_t mc_resp;
  ext_dev_pkg::obi_req_t  mem_req;
  ext_dev_pkg::obi_resp_t mem_resp;

  memcopy_periph u_memcopy_periph (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_req_i    (reg_req_i),
    .reg_rsp_o    (reg_rsp_o),
    .master_req_o (mc_req),
    .master_resp_i(mc_resp),
    .intr_o       (memcopy_intr_o)
  );

  obi_arbiter u_obi_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .m0_req_i (host_req_i),
    .m0_resp_o(host_resp_o),
    .m1_req_i (mc_req),
    .m1_resp_o(mc_resp),
    .s_req_o  (mem_req),
    .s_resp_i (mem_resp)
  );

  // Shared slow memory
  slow_memory u_slow_memory (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

endmodule

/* tests/ext_dev_checker.sv */
/* Scoreboard for ext_dev_top, sampling on the rising clock edge.
   Host writes must stay clear of a running copy's source and destination. */
`timescale 1ns/1ps
`include "ext_dev_defines.svh"

module ext_dev_checker (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ext_dev_pkg::reg_req_t  reg_req_i,
  input  ext_dev_pkg::reg_rsp_t  reg_rsp_i,
  input  ext_dev_pkg::obi_req_t  host_req_i,
  input  ext_dev_pkg::obi_resp_t host_resp_i,
  input  logic                   intr_i,
  input  ext_dev_pkg::data_t     exp_data_i,
  input  logic                   exp_chk_i,
  input  logic                   exp_err_i,
  output int                     err_cnt_o,
  output int                     chk_cnt_o
);

  ext_dev_pkg::data_t ref_mem [`EXT_MEM_WORDS];
  ext_dev_pkg::addr_t src_q;
  ext_dev_pkg::addr_t dst_q;
  ext_dev_pkg::addr_t cp_src;
  ext_dev_pkg::addr_t cp_dst;
  ext_dev_pkg::data_t cp_size;
  ext_dev_pkg::data_t pend_data;
  logic               cp_busy;
  logic               pend;
  logic               pend_we;
  int                 err_cnt = 0;
  int                 chk_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  task automatic flag_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  always @(posedge clk_i) begin
    ext_dev_pkg::word_idx_t wi;
    ext_dev_pkg::word_idx_t di;
    logic                   busy_now;
    busy_now = cp_busy;
    if (!rst_n_i) begin
      cp_busy = 1'b0;
      pend    = 1'b0;
      if (intr_i || host_resp_i.gnt || host_resp_i.rvalid) begin
        flag_error("DUT outputs active during reset");
      end
    end else begin
      // Read data was taken from the model at the grant
      if (host_resp_i.rvalid) begin
        if (!pend) begin
          flag_error("host rvalid with no request outstanding");
        end else if (!pend_we) begin
          chk_cnt++;
          if (host_resp_i.rdata !== pend_data) begin
            flag_error($sformatf("host read got %h, model holds %h",
                                 host_resp_i.rdata, pend_data));
          end
          if (exp_chk_i && host_resp_i.rdata !== exp_data_i) begin
            flag_error($sformatf("host read got %h, expected %h",
                                 host_resp_i.rdata, exp_data_i));
          end
        end
        pend = 1'b0;
      end
      if (host_resp_i.gnt) begin
        wi = host_req_i.addr[8:2];
        if (!host_req_i.req) flag_error("host grant without a request");
        pend      = 1'b1;
        pend_we   = host_req_i.we;
        pend_data = ref_mem[wi];
        for (int b = 0; b < `EXT_DATA_W / 8; b++) begin
          if (host_req_i.we && host_req_i.be[b]) begin
            ref_mem[wi][b*8 +: 8] = host_req_i.wdata[b*8 +: 8];
          end
        end
      end
      if (reg_req_i.valid) begin
        chk_cnt++;
        if (reg_rsp_i.ready !== 1'b1 || reg_rsp_i.error !== exp_err_i) begin
          flag_error($sformatf("register %h ready %b error %b, expected error %b",
                               reg_req_i.addr, reg_rsp_i.ready, reg_rsp_i.error, exp_err_i));
        end
        if (!reg_req_i.write && exp_chk_i && reg_rsp_i.rdata !== exp_data_i) begin
          flag_error($sformatf("register %h read %h, expected %h",
                               reg_req_i.addr, reg_rsp_i.rdata, exp_data_i));
        end
        if (reg_req_i.write && reg_req_i.addr == `MC_REG_SRC) src_q = reg_req_i.wdata;
        if (reg_req_i.write && reg_req_i.addr == `MC_REG_DST) dst_q = reg_req_i.wdata;
        // SIZE only starts a copy while idle
        if (reg_req_i.write && reg_req_i.addr == `MC_REG_SIZE && !busy_now &&
            reg_req_i.wdata != '0) begin
          cp_busy = 1'b1;
          cp_src  = src_q;
          cp_dst  = dst_q;
          cp_size = reg_req_i.wdata;
        end
      end
      // Each pulse closes exactly one copy, applied word by word
      if (intr_i) begin
        if (!busy_now) begin
          flag_error("interrupt pulse with no copy in progress");
        end else begin
          wi = cp_src[8:2];
          di = cp_dst[8:2];
          for (int i = 0; i < int'(cp_size); i++) begin
            ref_mem[di] = ref_mem[wi];
            wi++;
            di++;
          end
          cp_busy = 1'b0;
        end
      end
    end
  end

endmodule

/* tests/tb_ext_dev_top.sv */
/* Testbench for ext_dev_top, stepping through a table of bus operations.
   Comparisons happen in ext_dev_checker; the run is capped at 64 cycles per step. */
`timescale 1ns/1ps
`include "ext_dev_defines.svh"

module tb_ext_dev_top;

  typedef enum logic [2:0] {MEM_WR, MEM_RD, REG_WR, REG_RD, WAIT_INTR} step_kind_e;

  typedef struct packed {
    step_kind_e         kind;
    ext_dev_pkg::addr_t addr;
    ext_dev_pkg::data_t data;
    ext_dev_pkg::strb_t strb;
    ext_dev_pkg::data_t exp;
    logic               chk;
    logic               exp_err;
  } step_t;

  logic                   clk;
  logic                   rst_n;
  ext_dev_pkg::reg_req_t  reg_req;
  ext_dev_pkg::reg_rsp_t  reg_rsp;
  ext_dev_pkg::obi_req_t  host_req;
  ext_dev_pkg::obi_resp_t host_resp;
  logic                   memcopy_intr;
  ext_dev_pkg::data_t     exp_data;
  logic                   exp_chk;
  logic                   exp_err;
  int                     err_cnt;
  int                     chk_cnt;
  int                     cycle_limit;
  int                     cycle_cnt;
  int                     intr_seen;
  int                     intr_done;
  step_t                  steps[$];

  ext_dev_top u_ext_dev_top (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .host_req_i    (host_req),
    .host_resp_o   (host_resp),
    .memcopy_intr_o(memcopy_intr)
  );

  ext_dev_checker u_ext_dev_checker (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .reg_req_i  (reg_req),
    .reg_rsp_i  (reg_rsp),
    .host_req_i (host_req),
    .host_resp_i(host_resp),
    .intr_i     (memcopy_intr),
    .exp_data_i (exp_data),
    .exp_chk_i  (exp_chk),
    .exp_err_i  (exp_err),
    .err_cnt_o  (err_cnt),
    .chk_cnt_o  (chk_cnt)
  );

  always #4 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      intr_seen <= 0;
    end else if (memcopy_intr) begin
      intr_seen <= intr_seen + 1;
    end
  end

  function automatic void push_step(input step_kind_e kind, input ext_dev_pkg::addr_t addr,
                                    input ext_dev_pkg::data_t data, input ext_dev_pkg::strb_t strb,
                                    input ext_dev_pkg::data_t exp, input logic chk,
                                    input logic exp_err);
    steps.push_back('{kind, addr, data, strb, exp, chk, exp_err});
  endfunction

  // Program SRC and DST, start with SIZE, then confirm busy
  function automatic void push_copy(input ext_dev_pkg::addr_t src, input ext_dev_pkg::addr_t dst,
                                    input ext_dev_pkg::data_t words);
    push_step(REG_WR, `MC_REG_SRC, src, 4'hF, '0, 1'b0, 1'b0);
    push_step(REG_WR, `MC_REG_DST, dst, 4'hF, '0, 1'b0, 1'b0);
    push_step(REG_WR, `MC_REG_SIZE, words, 4'hF, '0, 1'b0, 1'b0);
    push_step(REG_RD, `MC_REG_STATUS, '0, 4'hF, 32'h1, 1'b1, 1'b0);
  endfunction

  function automatic void build_table();
    push_step(REG_RD, `MC_REG_STATUS, '0, 4'hF, 32'h0, 1'b1, 1'b0);
    for (int w = 0; w < `EXT_MEM_WORDS; w++) begin
      push_step(MEM_WR, 32'(w * 4), $urandom(), 4'hF, '0, 1'b0, 1'b0);
    end
    // Partial byte enables merge into the old word
    push_step(MEM_WR, 32'h1F0, 32'h11223344, 4'hF, '0, 1'b0, 1'b0);
    push_step(MEM_WR, 32'h1F0, 32'hAABBCCDD, 4'b0101, '0, 1'b0, 1'b0);
    push_step(MEM_RD, 32'h1F0, '0, 4'hF, 32'h11BB33DD, 1'b1, 1'b0);
    push_step(MEM_WR, 32'h1F0, 32'h55667788, 4'b1000, '0, 1'b0, 1'b0);
    push_step(MEM_RD, 32'h1F0, '0, 4'hF, 32'h55BB33DD, 1'b1, 1'b0);
    push_step(MEM_WR, 32'h1F4, 32'h0, 4'hF, '0, 1'b0, 1'b0);
    push_step(MEM_WR, 32'h1F4, 32'hFFFFFFFF, 4'b0110, '0, 1'b0, 1'b0);
    push_step(MEM_RD, 32'h1F4, '0, 4'hF, 32'h00FFFF00, 1'b1, 1'b0);
    // Register readback and decode errors
    push_step(REG_WR, `MC_REG_SRC, 32'h40, 4'hF, '0, 1'b0, 1'b0);
    push_step(REG_RD, `MC_REG_SRC, '0, 4'hF, 32'h40, 1'b1, 1'b0);
    push_step(REG_WR, `MC_REG_DST, 32'h100, 4'hF, '0, 1'b0, 1'b0);
    push_step(REG_RD, `MC_REG_DST, '0, 4'hF, 32'h100, 1'b1, 1'b0);
    push_step(REG_RD, 32'h10, '0, 4'hF, '0, 1'b0, 1'b1);
    push_step(REG_WR, 32'h24, 32'hDEAD, 4'hF, '0, 1'b0, 1'b1);
    // One word, then its neighbours
    push_copy(32'h000, 32'h100, 1);
    push_step(WAIT_INTR, '0, '0, '0, '0, 1'b0, 1'b0);
    push_step(REG_RD, `MC_REG_STATUS, '0, 4'hF, 32'h0, 1'b1, 1'b0);
    for (int a = 'hFC; a <= 'h104; a += 4) push_step(MEM_RD, a, '0, 4'hF, '0, 1'b0, 1'b0);
    push_copy(32'h010, 32'h120, 5);
    push_step(WAIT_INTR, '0, '0, '0, '0, 1'b0, 1'b0);
    for (int a = 'h11C; a <= 'h134; a += 4) push_step(MEM_RD, a, '0, 4'hF, '0, 1'b0, 1'b0);
    // Sixteen words with host reads elsewhere and a SIZE write while busy
    push_copy(32'h040, 32'h180, 16);
    push_step(REG_WR, `MC_REG_SIZE, 32'h3, 4'hF, '0, 1'b0, 1'b0);
    for (int a = 'hA0; a <= 'hB4; a += 4) push_step(MEM_RD, a, '0, 4'hF, '0, 1'b0, 1'b0);
    push_step(WAIT_INTR, '0, '0, '0, '0, 1'b0, 1'b0);
    push_step(REG_RD, `MC_REG_STATUS, '0, 4'hF, 32'h0, 1'b1, 1'b0);
    push_step(REG_RD, `MC_REG_SIZE, '0, 4'hF, 32'd16, 1'b1, 1'b0);
    for (int w = 0; w < `EXT_MEM_WORDS; w++) begin
      push_step(MEM_RD, 32'(w * 4), '0, 4'hF, '0, 1'b0, 1'b0);
    end
  endfunction

  // OBI request held until gnt, then wait for its rvalid
  task automatic host_access(input step_t st);
    host_req.req   = 1'b1;
    host_req.we    = (st.kind == MEM_WR);
    host_req.be    = st.strb;
    host_req.addr  = st.addr;
    host_req.wdata = st.data;
    do @(posedge clk); while (!host_resp.gnt);
    #1;
    host_req = '0;
    do @(posedge clk); while (!host_resp.rvalid);
    #1;
  endtask

  task automatic reg_access(input step_t st);
    reg_req.valid = 1'b1;
    reg_req.write = (st.kind == REG_WR);
    reg_req.addr  = st.addr;
    reg_req.wdata = st.data;
    reg_req.wstrb = st.strb;
    @(posedge clk);
    #1;
    reg_req = '0;
  endtask

  task automatic wait_for_intr();
    while (intr_seen == intr_done) begin
      @(posedge clk);
      #1;
    end
    intr_done++;
  endtask

  initial begin
    step_t      st;
    step_kind_e kind;
    int         errs_before;
    clk       = 1'b0;
    rst_n     = 1'b0;
    reg_req   = '0;
    host_req  = '0;
    exp_data  = '0;
    exp_chk   = 1'b0;
    exp_err   = 1'b0;
    intr_done = 0;
    void'($urandom(59));
    build_table();
    cycle_limit = steps.size() * 64;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    foreach (steps[i]) begin
      st          = steps[i];
      kind        = st.kind;
      errs_before = err_cnt;
      exp_data    = st.exp;
      exp_chk     = st.chk;
      exp_err     = st.exp_err;
      case (kind)
        MEM_WR, MEM_RD: host_access(st);
        REG_WR, REG_RD: reg_access(st);
        default:        wait_for_intr();
      endcase
      $display("Step %0d %s addr %h: %s", i, kind.name(), st.addr,
               (err_cnt == errs_before) ? "ok" : "failed");
    end
    $display("Steps %0d, checks %0d, errors %0d", steps.size(), chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* ext_dev_top.f */
+incdir+src
src/ext_dev_pkg.sv
src/slow_memory.sv
src/obi_arbiter.sv
src/memcopy_periph.sv
src/ext_dev_top.sv
tests/ext_dev_checker.sv
tests/tb_ext_dev_top.sv

/* Makefile */
TOP := tb_ext_dev_top

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f ext_dev_top.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean
